// ==== pulse_top.f ====
source/pulse_pkg.sv
source/pulse_param_regs.sv
source/pulse_timebase.sv
source/pulse_sequencer.sv
source/pulse_outputs.sv
source/pulse_top.sv
tb/pulse_top_assert.sv
tb/pulse_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pulse generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module pulse_top_tb \
	-f pulse_top.f \
	-o sim_pulse_top

# the simulator exits nonzero on failure, the log decides the result
./obj_dir/sim_pulse_top +verilator+error+limit+10 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi

// ==== tb/pulse_top_tb.sv ====
`timescale 1ns/1ps

module pulse_top_tb;
	import pulse_pkg::*;

	localparam int N_TESTS = 4;
	// frames watched after each commit
	localparam int FRAMES = 3;
	localparam int SHIFT = 8;

	logic clk_pll;
	logic reset;
	logic cfg_valid;
	reg_addr_e cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_data;
	logic cfg_ready;
	logic sync_on;
	logic pulse_on;
	logic inhib;

	// register values per test and per address
	logic [31:0] cfg_tab [N_TESTS][10];
	string names [N_TESTS];
	string test_name;
	int wd_cycles;

	pulse_top #(
		.PERIOD_SHIFT(SHIFT)
	) dut (
		.clk_pll(clk_pll),
		.reset(reset),
		.cfg_valid(cfg_valid),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.cfg_ready(cfg_ready),
		.sync_on(sync_on),
		.pulse_on(pulse_on),
		.inhib(inhib)
	);

	initial clk_pll = 1'b0;
	always #5 clk_pll = ~clk_pll;

	// legal random timings that end well inside two period units
	task automatic fill_test(input int t, input string nm, input int per,
		input int npi, input int flags, input bit with_nut);
		names[t] = nm;
		cfg_tab[t][REG_PERIOD] = per;
		cfg_tab[t][REG_P1WIDTH] = $urandom_range(9, 2);
		cfg_tab[t][REG_DELAY] = $urandom_range(39, 20);
		cfg_tab[t][REG_P2WIDTH] = $urandom_range(9, 2);
		cfg_tab[t][REG_NPI] = npi;
		cfg_tab[t][REG_BLOCK_DLY] = $urandom_range(6, 2);
		cfg_tab[t][REG_BLOCK_WIDTH] = $urandom_range(10, 3);
		cfg_tab[t][REG_NUT_WIDTH] = with_nut ? $urandom_range(14, 5) : 0;
		cfg_tab[t][REG_NUT_DELAY] = $urandom_range(29, 10);
		cfg_tab[t][REG_FLAGS] = flags;
	endtask

	// holds valid until the handshake completes
	task automatic write_reg(input reg_addr_e a, input logic [31:0] d);
		@(posedge clk_pll);
		#1;
		cfg_valid = 1'b1;
		cfg_addr = a;
		cfg_data = d;
		@(posedge clk_pll);
		while (!cfg_ready)
			@(posedge clk_pll);
		#1;
		cfg_valid = 1'b0;
	endtask

	task automatic wait_sync_rises(input int n);
		int seen;
		logic prev;
		seen = 0;
		prev = sync_on;
		while (seen < n) begin
			@(posedge clk_pll);
			if (sync_on && !prev)
				seen++;
			prev = sync_on;
		end
	endtask

	task automatic run_test(input int t);
		test_name = names[t];
		for (int a = 0; a < 10; a++)
			write_reg(reg_addr_e'(a), cfg_tab[t][a]);
		write_reg(REG_APPLY, 32'd0);
		// commit happens at the frame boundary
		while (!cfg_ready)
			@(posedge clk_pll);
		wait_sync_rises(FRAMES);
	endtask

	initial begin
		void'($urandom(32'h036c9cc3));
		fill_test(0, "cw", 1, 0, 3, 1'b0);
		fill_test(1, "hahn_nutation", 2, 1, 3, 1'b1);
		fill_test(2, "hahn_no_pump_no_block", 2, 1, 0, 1'b0);
		fill_test(3, "cpmg", 2, $urandom_range(5, 2), 3, 1'b1);
		wd_cycles = 2000;
		for (int t = 0; t < N_TESTS; t++)
			wd_cycles += 4 * (cfg_tab[t][REG_PERIOD] << SHIFT);
		test_name = "reset";
		reset = 1'b0;
		cfg_valid = 1'b0;
		cfg_addr = REG_PERIOD;
		cfg_data = '0;
		repeat (8) @(posedge clk_pll);
		#1;
		reset = 1'b1;
		// idle checks run here with nothing applied
		repeat (20) @(posedge clk_pll);
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		repeat (5) @(posedge clk_pll);
		#1;
		if (dut.u_chk.fail_flag) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "assertion failure at end of run");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// first assertion failure ends the run
	always @(negedge clk_pll) begin
		if (dut.u_chk.fail_flag) begin
			$display("MISMATCH test=%s expected=%0h actual=%0h", test_name,
				dut.u_chk.fail_exp, dut.u_chk.fail_act);
			$display("Simulation finished: FAIL");
			$fatal(1, "assertion failed");
		end
	end

	initial begin
		#1;
		repeat (wd_cycles) @(posedge clk_pll);
		$display("watchdog expired during test %s", test_name);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

endmodule

// ==== tb/pulse_top_assert.sv ====
`timescale 1ns/1ps

module pulse_top_assert #(
	parameter int PERIOD_SHIFT = 8
) (
	input logic clk_pll,
	input logic reset,
	input logic cfg_valid,
	input pulse_pkg::reg_addr_e cfg_addr,
	input logic [pulse_pkg::CFG_DATA_W-1:0] cfg_data,
	input logic cfg_ready,
	input logic sync_on,
	input logic pulse_on,
	input logic inhib
);
	import pulse_pkg::*;

	// set by any failing assertion
	logic fail_flag = 1'b0;
	logic [31:0] fail_exp = '0;
	logic [31:0] fail_act = '0;

	// staged, pending and applied register copies
	logic [31:0] stg [0:9];
	logic [31:0] pend [0:9];
	logic [31:0] act [0:9];
	logic [31:0] cur [0:9];
	logic wr, apply_seen, pend_armed, started, sync_q, ready_q;
	logic sync_rise, live;
	// position inside the frame counted from the sync_on rise
	logic [31:0] pos_q, pos, frame_len, act_len;
	logic [31:0] p1w, dly, p2w, npi, bdly, bw, nw, nd, head, step, q, wq;
	logic cw, in_pi, in_win, nut, exp_sync, exp_pulse, exp_inhib;

	assign wr = cfg_valid && cfg_ready;
	assign act_len = act[REG_PERIOD] << PERIOD_SHIFT;

	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			apply_seen <= 1'b0;
			pend_armed <= 1'b0;
			started <= 1'b0;
			sync_q <= 1'b0;
			ready_q <= 1'b1;
			pos_q <= '0;
			for (int i = 0; i < 10; i++) begin
				stg[i] <= '0;
				act[i] <= '0;
			end
		end else begin
			sync_q <= sync_on;
			ready_q <= cfg_ready;
			if (wr && cfg_addr <= REG_FLAGS)
				stg[cfg_addr] <= cfg_data;
			// snapshot of the staging bank taken with the apply
			if (wr && cfg_addr == REG_APPLY) begin
				for (int i = 0; i < 10; i++)
					pend[i] <= stg[i];
				apply_seen <= 1'b1;
			end
			// the sync rise after ready returns starts the new frame
			if (cfg_ready && !ready_q && apply_seen)
				pend_armed <= 1'b1;
			if (sync_rise) begin
				started <= 1'b1;
				pos_q <= '0;
				if (pend_armed) begin
					for (int i = 0; i < 10; i++)
						act[i] <= pend[i];
					pend_armed <= 1'b0;
				end
			end else begin
				pos_q <= pos_q + 1;
			end
		end
	end

	// expected pin levels from the frame rules
	always_comb begin
		sync_rise = sync_on && !sync_q;
		live = started || sync_rise;
		for (int i = 0; i < 10; i++)
			cur[i] = (sync_rise && pend_armed) ? pend[i] : act[i];
		pos = sync_rise ? '0 : pos_q + 1;
		frame_len = cur[REG_PERIOD] << PERIOD_SHIFT;
		p1w = cur[REG_P1WIDTH];
		dly = cur[REG_DELAY];
		p2w = cur[REG_P2WIDTH];
		npi = cur[REG_NPI];
		bdly = cur[REG_BLOCK_DLY];
		bw = cur[REG_BLOCK_WIDTH];
		nw = cur[REG_NUT_WIDTH];
		nd = cur[REG_NUT_DELAY];
		cw = (npi == 0);
		// first pi pulse starts after p1 and one delay and repeats every step
		head = p1w + dly;
		step = p2w + dly;
		q = pos - head;
		wq = q - p2w - bdly;
		in_pi = 1'b0;
		in_win = 1'b0;
		if (!cw && step != 0) begin
			in_pi = (pos >= head) && (q / step < npi) && (q % step < p2w);
			in_win = (pos >= head + p2w + bdly) && (wq / step < npi) && (wq % step < bw);
		end
		// nutation run ends nd cycles before the frame does
		nut = (nw != 0) && (pos + nd + nw >= frame_len) && (pos + nd < frame_len);
		exp_sync = cw ? (pos == 0) : (pos < head + p2w + bdly);
		exp_pulse = cw ? 1'b1 : ((pos < p1w) && cur[REG_FLAGS][0]) || in_pi || nut;
		exp_inhib = cw ? 1'b0 : (cur[REG_FLAGS][1] && !in_win);
	end

	a_idle: assert property (@(posedge clk_pll) disable iff (!reset)
		!apply_seen |-> cfg_ready && !sync_on && !pulse_on && !inhib)
	else begin
		$error("outputs active before the first apply");
		fail_exp = 32'h8;
		fail_act = {28'd0, $sampled(cfg_ready), $sampled(sync_on),
			$sampled(pulse_on), $sampled(inhib)};
		fail_flag = 1'b1;
	end

	a_parked: assert property (@(posedge clk_pll) disable iff (!reset)
		apply_seen && !started && !sync_on |-> !pulse_on && !inhib)
	else begin
		$error("pins active before the first frame");
		fail_exp = 32'h0;
		fail_act = {30'd0, $sampled(pulse_on), $sampled(inhib)};
		fail_flag = 1'b1;
	end

	a_busy: assert property (@(posedge clk_pll) disable iff (!reset)
		wr && cfg_addr == REG_APPLY |=> !cfg_ready)
	else begin
		$error("cfg_ready high while an apply waits");
		fail_exp = 32'h0;
		fail_act = 32'h1;
		fail_flag = 1'b1;
	end

	a_commit: assert property (@(posedge clk_pll) disable iff (!reset)
		$rose(cfg_ready) && apply_seen |=> $rose(sync_on))
	else begin
		$error("new frame did not follow the commit");
		fail_exp = 32'h1;
		fail_act = {31'd0, $sampled(sync_on)};
		fail_flag = 1'b1;
	end

	a_frame: assert property (@(posedge clk_pll) disable iff (!reset)
		started |-> (sync_rise == (pos_q + 1 == act_len)))
	else begin
		$error("sync_on spacing differs from the period");
		fail_exp = $sampled(act_len);
		fail_act = $sampled(pos_q) + 1;
		fail_flag = 1'b1;
	end

	a_sync: assert property (@(posedge clk_pll) disable iff (!reset)
		live |-> sync_on == exp_sync)
	else begin
		$error("sync_on level wrong");
		fail_exp = {31'd0, $sampled(exp_sync)};
		fail_act = {31'd0, $sampled(sync_on)};
		fail_flag = 1'b1;
	end

	a_pulse: assert property (@(posedge clk_pll) disable iff (!reset)
		live |-> pulse_on == exp_pulse)
	else begin
		$error("pulse_on level wrong");
		fail_exp = {31'd0, $sampled(exp_pulse)};
		fail_act = {31'd0, $sampled(pulse_on)};
		fail_flag = 1'b1;
	end

	a_inhib: assert property (@(posedge clk_pll) disable iff (!reset)
		live |-> inhib == exp_inhib)
	else begin
		$error("inhib level wrong");
		fail_exp = {31'd0, $sampled(exp_inhib)};
		fail_act = {31'd0, $sampled(inhib)};
		fail_flag = 1'b1;
	end

endmodule

bind pulse_top pulse_top_assert #(
	.PERIOD_SHIFT(PERIOD_SHIFT)
) u_chk (
	.clk_pll(clk_pll),
	.reset(reset),
	.cfg_valid(cfg_valid),
	.cfg_addr(cfg_addr),
	.cfg_data(cfg_data),
	.cfg_ready(cfg_ready),
	.sync_on(sync_on),
	.pulse_on(pulse_on),
	.inhib(inhib)
);

// ==== source/pulse_top.sv ====
`timescale 1ns/1ps

module pulse_top #(
	parameter int CNT_W = pulse_pkg::DEF_CNT_W,
	parameter int TIME_W = pulse_pkg::DEF_TIME_W,
	parameter int PERIOD_SHIFT = pulse_pkg::DEF_PERIOD_SHIFT
) (
	input logic clk_pll,
	input logic reset,
	input logic cfg_valid,
	input pulse_pkg::reg_addr_e cfg_addr,
	input logic [pulse_pkg::CFG_DATA_W-1:0] cfg_data,
	output logic cfg_ready,
	output logic sync_on,
	output logic pulse_on,
	output logic inhib
);
	import pulse_pkg::*;

	// active settings
	logic [PERIOD_W-1:0] period;
	logic [TIME_W-1:0] p1width, delay, p2width;
	logic [NPI_W-1:0] n_pi;
	logic [TIME_W-1:0] block_dly, block_width;
	logic [TIME_W-1:0] nut_width, nut_delay;
	logic pump, block_en;

	// timebase
	logic [CNT_W-1:0] count;
	logic frame_start;

	// sequencer to output stage
	logic seq_pulse, seq_sync, seq_window;
	seq_mode_e mode;

	pulse_param_regs #(
		.TIME_W(TIME_W)
	) u_regs (
		.clk_pll(clk_pll),
		.reset(reset),
		.cfg_valid(cfg_valid),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.cfg_ready(cfg_ready),
		.frame_start(frame_start),
		.period(period),
		.p1width(p1width),
		.delay(delay),
		.p2width(p2width),
		.n_pi(n_pi),
		.block_dly(block_dly),
		.block_width(block_width),
		.nut_width(nut_width),
		.nut_delay(nut_delay),
		.pump(pump),
		.block_en(block_en)
	);

	pulse_timebase #(
		.CNT_W(CNT_W),
		.PERIOD_SHIFT(PERIOD_SHIFT)
	) u_timebase (
		.clk_pll(clk_pll),
		.reset(reset),
		.period(period),
		.count(count),
		.frame_start(frame_start)
	);

	pulse_sequencer #(
		.TIME_W(TIME_W)
	) u_seq (
		.clk_pll(clk_pll),
		.reset(reset),
		.frame_start(frame_start),
		.p1width(p1width),
		.delay(delay),
		.p2width(p2width),
		.n_pi(n_pi),
		.block_dly(block_dly),
		.block_width(block_width),
		.seq_pulse(seq_pulse),
		.seq_sync(seq_sync),
		.seq_window(seq_window),
		.mode(mode)
	);

	pulse_outputs #(
		.CNT_W(CNT_W),
		.TIME_W(TIME_W),
		.PERIOD_SHIFT(PERIOD_SHIFT)
	) u_out (
		.clk_pll(clk_pll),
		.reset(reset),
		.count(count),
		.period(period),
		.mode(mode),
		.seq_pulse(seq_pulse),
		.seq_sync(seq_sync),
		.seq_window(seq_window),
		.nut_width(nut_width),
		.nut_delay(nut_delay),
		.pump(pump),
		.block_en(block_en),
		.sync_on(sync_on),
		.pulse_on(pulse_on),
		.inhib(inhib)
	);

endmodule

// ==== source/pulse_outputs.sv ====
`timescale 1ns/1ps

module pulse_outputs #(
	parameter int CNT_W = 32,
	parameter int TIME_W = 16,
	parameter int PERIOD_SHIFT = 8
) (
	input logic clk_pll,
	input logic reset,
	input logic [CNT_W-1:0] count,
	input logic [pulse_pkg::PERIOD_W-1:0] period,
	input pulse_pkg::seq_mode_e mode,
	input logic seq_pulse,
	input logic seq_sync,
	input logic seq_window,
	input logic [TIME_W-1:0] nut_width,
	input logic [TIME_W-1:0] nut_delay,
	input logic pump,
	input logic block_en,
	output logic sync_on,
	output logic pulse_on,
	output logic inhib
);
	import pulse_pkg::*;

	logic [CNT_W-1:0] frame_len;
	// count and settings delayed to line up with the sequencer
	logic [CNT_W-1:0] count_d;
	logic [CNT_W-1:0] nut_lo_q, nut_hi_q;
	logic nut_en_q;
	logic run_q, pump_q, block_q;
	// inside the first pulse of the frame
	logic p1_run, p1_now;
	logic nut_on;
	logic sync_c, pulse_c, inhib_c;

	assign frame_len = CNT_W'(period) << PERIOD_SHIFT;

	always_ff @(posedge clk_pll) begin
		count_d <= count;
		// nutation pulse ends nut_delay cycles before frame end
		nut_hi_q <= frame_len - CNT_W'(nut_delay);
		nut_lo_q <= frame_len - CNT_W'(nut_delay) - CNT_W'(nut_width);
	end

	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			nut_en_q <= 1'b0;
			run_q <= 1'b0;
			pump_q <= 1'b0;
			block_q <= 1'b0;
			p1_run <= 1'b0;
		end else begin
			nut_en_q <= (nut_width != '0);
			// nothing leaves the pins while the timebase is parked
			run_q <= (period != '0);
			pump_q <= pump;
			block_q <= block_en;
			p1_run <= p1_now;
		end
	end

	// first pulse starts at count 0 and lasts until seq_pulse drops
	assign p1_now = seq_pulse && ((count_d == '0) || p1_run);
	assign nut_on = nut_en_q && (count_d >= nut_lo_q) && (count_d < nut_hi_q);

	always_comb begin
		if (!run_q) begin
			sync_c = 1'b0;
			pulse_c = 1'b0;
			inhib_c = 1'b0;
		end else if (mode == MODE_CW) begin
			// switch held open, receiver never blocked
			sync_c = seq_sync;
			pulse_c = 1'b1;
			inhib_c = 1'b0;
		end else begin
			sync_c = seq_sync;
			pulse_c = (seq_pulse && (!p1_now || pump_q)) || nut_on;
			inhib_c = block_q && !seq_window;
		end
	end

	// pins sit two cycles behind count
	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			sync_on <= 1'b0;
			pulse_on <= 1'b0;
			inhib <= 1'b0;
		end else begin
			sync_on <= sync_c;
			pulse_on <= pulse_c;
			inhib <= inhib_c;
		end
	end

endmodule

// ==== source/pulse_sequencer.sv ====
`timescale 1ns/1ps

module pulse_sequencer #(
	parameter int TIME_W = 16
) (
	input logic clk_pll,
	input logic reset,
	input logic frame_start,
	input logic [TIME_W-1:0] p1width,
	input logic [TIME_W-1:0] delay,
	input logic [TIME_W-1:0] p2width,
	input logic [pulse_pkg::NPI_W-1:0] n_pi,
	input logic [TIME_W-1:0] block_dly,
	input logic [TIME_W-1:0] block_width,
	output logic seq_pulse,
	output logic seq_sync,
	output logic seq_window,
	output pulse_pkg::seq_mode_e mode
);
	import pulse_pkg::*;

	seq_state_e state, state_n;
	// cycles left in the current phase after this one
	logic [TIME_W-1:0] cnt, cnt_n;
	// pi pulses started so far in this frame
	logic [NPI_W-1:0] pi_cnt, pi_n;
	seq_mode_e mode_c;
	// low time between a window closing and the next pi pulse
	logic [TIME_W-1:0] gap_rest;

	// hahn is a one pulse cpmg, both share the same phases
	assign mode_c = (n_pi == '0) ? MODE_CW :
		((n_pi == NPI_W'(1)) ? MODE_HAHN : MODE_CPMG);

	assign gap_rest = delay - block_dly - block_width;

	// state and cnt_n describe the phase of the current count
	always_comb begin
		state_n = state;
		cnt_n = cnt;
		pi_n = pi_cnt;
		if (frame_start) begin
			// restart the frame, first pulse covers count 0
			pi_n = '0;
			if (mode_c == MODE_CW) begin
				state_n = S_IDLE;
				cnt_n = '0;
			end else begin
				state_n = S_P1;
				cnt_n = p1width - 1'b1;
			end
		end else if (mode_c != MODE_CW) begin
			if (cnt != '0) begin
				cnt_n = cnt - 1'b1;
			end else begin
				// phase finished, reload for the next one
				case (state)
				S_P1: begin
					state_n = S_GAP;
					cnt_n = delay - 1'b1;
				end
				S_GAP: begin
					state_n = S_PI;
					cnt_n = p2width - 1'b1;
					pi_n = pi_cnt + 1'b1;
				end
				S_PI: begin
					// window may open right after the pulse
					if (block_dly != '0) begin
						state_n = S_HOLD;
						cnt_n = block_dly - 1'b1;
					end else begin
						state_n = S_WINDOW;
						cnt_n = block_width - 1'b1;
					end
				end
				S_HOLD: begin
					state_n = S_WINDOW;
					cnt_n = block_width - 1'b1;
				end
				S_WINDOW: begin
					if (pi_cnt == n_pi) begin
						state_n = S_DONE;
					end else if (gap_rest != '0) begin
						state_n = S_GAP;
						cnt_n = gap_rest - 1'b1;
					end else begin
						// window closes exactly at the next pi pulse
						state_n = S_PI;
						cnt_n = p2width - 1'b1;
						pi_n = pi_cnt + 1'b1;
					end
				end
				// idle and done wait for the next frame
				default: state_n = state;
				endcase
			end
		end
	end

	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			state <= S_IDLE;
			cnt <= '0;
			pi_cnt <= '0;
			seq_pulse <= 1'b0;
			seq_sync <= 1'b0;
			seq_window <= 1'b0;
			mode <= MODE_CW;
		end else begin
			state <= state_n;
			cnt <= cnt_n;
			pi_cnt <= pi_n;
			// outputs trail count by one cycle
			seq_pulse <= (state_n == S_P1) || (state_n == S_PI);
			seq_window <= (state_n == S_WINDOW);
			// trigger drops at the first window, or after one cycle in cw
			seq_sync <= frame_start ||
				(seq_sync && (mode_c != MODE_CW) && (state_n != S_WINDOW));
			mode <= mode_c;
		end
	end

endmodule

// ==== source/pulse_timebase.sv ====
`timescale 1ns/1ps

module pulse_timebase #(
	parameter int CNT_W = 32,
	parameter int PERIOD_SHIFT = 8
) (
	input logic clk_pll,
	input logic reset,
	input logic [pulse_pkg::PERIOD_W-1:0] period,
	output logic [CNT_W-1:0] count,
	output logic frame_start
);

	// frame length in cycles
	logic [CNT_W-1:0] frame_len;
	logic last_cycle;

	assign frame_len = CNT_W'(period) << PERIOD_SHIFT;

	// a zero period parks the counter at 0
	assign last_cycle = (frame_len == '0) || (count == frame_len - 1'b1);

	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			count <= '0;
		end else if (last_cycle) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// stays high while parked, so a pending apply still commits
	assign frame_start = (count == '0);

endmodule

// ==== source/pulse_param_regs.sv ====
`timescale 1ns/1ps

module pulse_param_regs #(
	parameter int TIME_W = 16
) (
	input logic clk_pll,
	input logic reset,
	input logic cfg_valid,
	input pulse_pkg::reg_addr_e cfg_addr,
	input logic [pulse_pkg::CFG_DATA_W-1:0] cfg_data,
	output logic cfg_ready,
	input logic frame_start,
	output logic [pulse_pkg::PERIOD_W-1:0] period,
	output logic [TIME_W-1:0] p1width,
	output logic [TIME_W-1:0] delay,
	output logic [TIME_W-1:0] p2width,
	output logic [pulse_pkg::NPI_W-1:0] n_pi,
	output logic [TIME_W-1:0] block_dly,
	output logic [TIME_W-1:0] block_width,
	output logic [TIME_W-1:0] nut_width,
	output logic [TIME_W-1:0] nut_delay,
	output logic pump,
	output logic block_en
);
	import pulse_pkg::*;

	// staging bank, written through the cfg port
	logic [PERIOD_W-1:0] stg_period;
	logic [TIME_W-1:0] stg_p1width, stg_delay, stg_p2width;
	logic [NPI_W-1:0] stg_n_pi;
	logic [TIME_W-1:0] stg_block_dly, stg_block_width;
	logic [TIME_W-1:0] stg_nut_width, stg_nut_delay;
	logic stg_pump, stg_block;

	// active bank, seen by the rest of the design
	logic [PERIOD_W-1:0] act_period;
	logic [TIME_W-1:0] act_p1width, act_delay, act_p2width;
	logic [NPI_W-1:0] act_n_pi;
	logic [TIME_W-1:0] act_block_dly, act_block_width;
	logic [TIME_W-1:0] act_nut_width, act_nut_delay;
	logic act_pump, act_block;

	logic apply_pending;
	logic wr_en;
	logic commit;

	// no writes accepted while an apply waits for the frame boundary
	assign cfg_ready = !apply_pending;
	assign wr_en = cfg_valid && cfg_ready;
	assign commit = frame_start && apply_pending;

	// staging decode
	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			stg_period <= '0;
			stg_p1width <= '0;
			stg_delay <= '0;
			stg_p2width <= '0;
			stg_n_pi <= '0;
			stg_block_dly <= '0;
			stg_block_width <= '0;
			stg_nut_width <= '0;
			stg_nut_delay <= '0;
			stg_pump <= 1'b0;
			stg_block <= 1'b0;
		end else if (wr_en) begin
			case (cfg_addr)
			REG_PERIOD: stg_period <= cfg_data[PERIOD_W-1:0];
			REG_P1WIDTH: stg_p1width <= cfg_data[TIME_W-1:0];
			REG_DELAY: stg_delay <= cfg_data[TIME_W-1:0];
			REG_P2WIDTH: stg_p2width <= cfg_data[TIME_W-1:0];
			REG_NPI: stg_n_pi <= cfg_data[NPI_W-1:0];
			REG_BLOCK_DLY: stg_block_dly <= cfg_data[TIME_W-1:0];
			REG_BLOCK_WIDTH: stg_block_width <= cfg_data[TIME_W-1:0];
			REG_NUT_WIDTH: stg_nut_width <= cfg_data[TIME_W-1:0];
			REG_NUT_DELAY: stg_nut_delay <= cfg_data[TIME_W-1:0];
			REG_FLAGS: begin
				stg_pump <= cfg_data[0];
				stg_block <= cfg_data[1];
			end
			// REG_APPLY and unknown addresses leave the bank alone
			default: stg_period <= stg_period;
			endcase
		end
	end

	// one pending apply, cleared when the bank is copied
	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			apply_pending <= 1'b0;
		end else if (commit) begin
			apply_pending <= 1'b0;
		end else if (wr_en && cfg_addr == REG_APPLY) begin
			apply_pending <= 1'b1;
		end
	end

	// copy the whole bank at the frame boundary
	always_ff @(posedge clk_pll) begin
		if (!reset) begin
			act_period <= '0;
			act_p1width <= '0;
			act_delay <= '0;
			act_p2width <= '0;
			act_n_pi <= '0;
			act_block_dly <= '0;
			act_block_width <= '0;
			act_nut_width <= '0;
			act_nut_delay <= '0;
			act_pump <= 1'b0;
			act_block <= 1'b0;
		end else if (commit) begin
			act_period <= stg_period;
			act_p1width <= stg_p1width;
			act_delay <= stg_delay;
			act_p2width <= stg_p2width;
			act_n_pi <= stg_n_pi;
			act_block_dly <= stg_block_dly;
			act_block_width <= stg_block_width;
			act_nut_width <= stg_nut_width;
			act_nut_delay <= stg_nut_delay;
			act_pump <= stg_pump;
			act_block <= stg_block;
		end
	end

	// new values already show in the frame_start cycle itself,
	// so the sequencer loads the first phase with them
	assign period = commit ? stg_period : act_period;
	assign p1width = commit ? stg_p1width : act_p1width;
	assign delay = commit ? stg_delay : act_delay;
	assign p2width = commit ? stg_p2width : act_p2width;
	assign n_pi = commit ? stg_n_pi : act_n_pi;
	assign block_dly = commit ? stg_block_dly : act_block_dly;
	assign block_width = commit ? stg_block_width : act_block_width;
	assign nut_width = commit ? stg_nut_width : act_nut_width;
	assign nut_delay = commit ? stg_nut_delay : act_nut_delay;
	assign pump = commit ? stg_pump : act_pump;
	assign block_en = commit ? stg_block : act_block;

endmodule

// ==== source/pulse_pkg.sv ====
package pulse_pkg;

	// configuration write data width
	localparam int CFG_DATA_W = 32;

	// defaults for the top level parameters
	localparam int DEF_CNT_W = 32;
	localparam int DEF_TIME_W = 16;
	// small period unit keeps simulation short
	localparam int DEF_PERIOD_SHIFT = 8;

	// period register and pi pulse count widths
	localparam int PERIOD_W = 16;
	localparam int NPI_W = 8;

	// configuration register addresses
	typedef enum logic [3:0] {
		REG_PERIOD = 4'd0,
		REG_P1WIDTH = 4'd1,
		REG_DELAY = 4'd2,
		REG_P2WIDTH = 4'd3,
		REG_NPI = 4'd4,
		REG_BLOCK_DLY = 4'd5,
		REG_BLOCK_WIDTH = 4'd6,
		REG_NUT_WIDTH = 4'd7,
		REG_NUT_DELAY = 4'd8,
		REG_FLAGS = 4'd9,
		REG_APPLY = 4'd10
	} reg_addr_e;

	// sequence mode, follows from n_pi
	typedef enum logic [1:0] {
		MODE_CW = 2'd0,
		MODE_HAHN = 2'd1,
		MODE_CPMG = 2'd2
	} seq_mode_e;

	// pulsed sequence phases
	typedef enum logic [2:0] {
		S_IDLE = 3'd0,
		S_P1 = 3'd1,
		S_GAP = 3'd2,
		S_PI = 3'd3,
		S_HOLD = 3'd4,
		S_WINDOW = 3'd5,
		S_DONE = 3'd6
	} seq_state_e;

endpackage
